// File: design/array_pkg.sv
package array_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // array and table sizes
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int NUM_TRANS  = 8;
  localparam int STM_FRAMES = 4;
  localparam int STM_ADDR_W = 5;  // frame * NUM_TRANS + element
  localparam int MOD_DEPTH  = 16;
  localparam int MOD_ADDR_W = 4;
  localparam int DATA_W     = 16;

  localparam int ELEM_W      = 3;  // element index within a frame
  localparam int FRAME_W     = 2;
  localparam int STM_CYCLE_W = 3;  // holds 1..STM_FRAMES
  localparam int MOD_CYCLE_W = 5;  // holds 1..MOD_DEPTH
  localparam int SAMPLE_W    = 8;  // intensity, phase, mod sample
  localparam int TIME_W      = 8;  // one carrier period is 2**TIME_W cycles

  // ~~~~~~~~~~~~~~~~~~~~
  // host write decode
  // ~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    WR_STM = 2'd0,  // intensity in [15:8], phase in [7:0]
    WR_MOD = 2'd1,  // sample in [7:0]
    WR_CFG = 2'd2
  } wr_target_t;

  typedef enum logic [1:0] {
    CFG_STM_CYCLE = 2'd0,  // frames used
    CFG_MOD_CYCLE = 2'd1,  // samples used
    CFG_ENABLE    = 2'd2   // bit 0
  } cfg_addr_t;

endpackage

// File: design/controller.sv
`timescale 1ns/1ps
module controller (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   wr_en,
  input  array_pkg::wr_target_t                 wr_sel,
  input  wire  [array_pkg::STM_ADDR_W-1:0]      wr_addr,
  input  wire  [array_pkg::DATA_W-1:0]          wr_data,
  output logic                                  stm_wr,
  output logic                                  mod_wr,
  output logic [array_pkg::STM_ADDR_W-1:0]      tbl_addr,
  output logic [array_pkg::DATA_W-1:0]          tbl_data,
  output logic [array_pkg::STM_CYCLE_W-1:0]     stm_cycle,
  output logic [array_pkg::MOD_CYCLE_W-1:0]     mod_cycle,
  output logic                                  enable,
  output logic                                  restart
);

  array_pkg::cfg_addr_t cfg_addr;
  logic                 cfg_wr;

  assign cfg_addr = array_pkg::cfg_addr_t'(wr_addr[1:0]);
  assign cfg_wr   = wr_en && (wr_sel == array_pkg::WR_CFG);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stm_wr    <= 1'b0;
      mod_wr    <= 1'b0;
      stm_cycle <= array_pkg::STM_CYCLE_W'(1);
      mod_cycle <= array_pkg::MOD_CYCLE_W'(1);
      enable    <= 1'b0;
      restart   <= 1'b0;
    end else begin
      stm_wr  <= wr_en && (wr_sel == array_pkg::WR_STM);
      mod_wr  <= wr_en && (wr_sel == array_pkg::WR_MOD);
      restart <= 1'b0;
      if (cfg_wr) begin
        case (cfg_addr)
          array_pkg::CFG_STM_CYCLE: stm_cycle <= wr_data[array_pkg::STM_CYCLE_W-1:0];
          array_pkg::CFG_MOD_CYCLE: mod_cycle <= wr_data[array_pkg::MOD_CYCLE_W-1:0];
          array_pkg::CFG_ENABLE: begin
            enable  <= wr_data[0];
            restart <= wr_data[0] && !enable;  // rising edge of enable only
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tbl_addr <= wr_addr;
      tbl_data <= wr_data;
    end
  end

  a_stm_cycle_range: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_wr && cfg_addr == array_pkg::CFG_STM_CYCLE
      |=> stm_cycle inside {[1:array_pkg::STM_FRAMES]})
    else $error("stm_cycle written out of range: %0d", stm_cycle);

  a_mod_cycle_range: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_wr && cfg_addr == array_pkg::CFG_MOD_CYCLE
      |=> mod_cycle inside {[1:array_pkg::MOD_DEPTH]})
    else $error("mod_cycle written out of range: %0d", mod_cycle);

endmodule

// File: design/time_cnt_generator.sv
`timescale 1ns/1ps
module time_cnt_generator (
  input  wire                              clk,
  input  wire                              rst_n,
  output logic [array_pkg::TIME_W-1:0]     time_cnt,
  output logic                             update
);

  // carrier counter, wraps every 256 cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      time_cnt <= '0;
    end else begin
      time_cnt <= time_cnt + 1'b1;
    end
  end

  // registered one count early so it lines up with the last count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      update <= 1'b0;
    end else begin
      update <= (time_cnt == array_pkg::TIME_W'(2**array_pkg::TIME_W - 2));
    end
  end

endmodule

// File: design/stm.sv
`timescale 1ns/1ps
module stm (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   update,
  input  wire                                   enable,
  input  wire                                   restart,
  input  wire  [array_pkg::STM_CYCLE_W-1:0]     stm_cycle,
  input  wire                                   stm_wr,
  input  wire  [array_pkg::STM_ADDR_W-1:0]      tbl_addr,
  input  wire  [array_pkg::DATA_W-1:0]          tbl_data,
  output logic [array_pkg::SAMPLE_W-1:0]        intensity,
  output logic [array_pkg::SAMPLE_W-1:0]        phase,
  output logic [array_pkg::ELEM_W-1:0]          elem_idx,
  output logic                                  dout_valid
);

  typedef enum logic {
    ST_IDLE,
    ST_READ
  } state_t;

  state_t                           state;
  logic [array_pkg::DATA_W-1:0]     pattern_mem [array_pkg::NUM_TRANS * array_pkg::STM_FRAMES];
  logic [array_pkg::DATA_W-1:0]     rd_data;
  logic [array_pkg::FRAME_W-1:0]    frame_idx;
  logic [array_pkg::FRAME_W-1:0]    cur_frame;
  logic [array_pkg::FRAME_W-1:0]    rd_frame;
  logic [array_pkg::STM_CYCLE_W-1:0] frame_inc;
  logic [array_pkg::ELEM_W-1:0]     rd_cnt;
  logic                             start;

  assign start     = update && enable;
  assign cur_frame = restart ? '0 : frame_idx;  // restart on an update plays frame 0
  assign frame_inc = array_pkg::STM_CYCLE_W'(cur_frame) + 1'b1;

  // ~~~~~~~~~~~~~~~~~~~~
  // frame sequencing
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      frame_idx <= '0;
      rd_frame  <= '0;
      rd_cnt    <= '0;
    end else begin
      if (start) begin
        frame_idx <= (frame_inc >= stm_cycle) ? '0 : frame_inc[array_pkg::FRAME_W-1:0];
      end else if (restart) begin
        frame_idx <= '0;
      end

      case (state)
        ST_IDLE: begin
          if (start) begin
            state    <= ST_READ;
            rd_frame <= cur_frame;
            rd_cnt   <= '0;
          end
        end
        ST_READ: begin
          rd_cnt <= rd_cnt + 1'b1;
          if (rd_cnt == array_pkg::ELEM_W'(array_pkg::NUM_TRANS - 1)) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // pattern table
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (stm_wr) begin
      pattern_mem[tbl_addr] <= tbl_data;
    end
    rd_data <= pattern_mem[{rd_frame, rd_cnt}];  // one cycle read latency
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dout_valid <= 1'b0;
      elem_idx   <= '0;
    end else begin
      dout_valid <= (state == ST_READ);
      elem_idx   <= rd_cnt;
    end
  end

  assign intensity = rd_data[array_pkg::DATA_W-1:array_pkg::SAMPLE_W];
  assign phase     = rd_data[array_pkg::SAMPLE_W-1:0];

  a_stream_len: assert property (@(posedge clk) disable iff (!rst_n)
    dout_valid [*array_pkg::NUM_TRANS] |=> !dout_valid)
    else $error("stm stream longer than %0d elements", array_pkg::NUM_TRANS);

endmodule

// File: design/modulation.sv
`timescale 1ns/1ps
module modulation (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   update,
  input  wire                                   enable,
  input  wire                                   restart,
  input  wire  [array_pkg::MOD_CYCLE_W-1:0]     mod_cycle,
  input  wire                                   mod_wr,
  input  wire  [array_pkg::STM_ADDR_W-1:0]      tbl_addr,
  input  wire  [array_pkg::DATA_W-1:0]          tbl_data,
  output logic [array_pkg::SAMPLE_W-1:0]        mod_value
);

  logic [array_pkg::SAMPLE_W-1:0]    mod_mem [array_pkg::MOD_DEPTH];
  logic [array_pkg::MOD_ADDR_W-1:0]  mod_idx;
  logic [array_pkg::MOD_ADDR_W-1:0]  cur_idx;
  logic [array_pkg::MOD_CYCLE_W-1:0] idx_inc;
  logic                              step;

  assign step    = update && enable;
  assign cur_idx = restart ? '0 : mod_idx;
  assign idx_inc = array_pkg::MOD_CYCLE_W'(cur_idx) + 1'b1;

  always_ff @(posedge clk) begin
    if (mod_wr) begin
      mod_mem[tbl_addr[array_pkg::MOD_ADDR_W-1:0]] <= tbl_data[array_pkg::SAMPLE_W-1:0];
    end
  end

  // sample is held until the next enabled update
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mod_idx   <= '0;
      mod_value <= '0;
    end else if (step) begin
      mod_value <= mod_mem[cur_idx];
      mod_idx   <= (idx_inc >= mod_cycle) ? '0 : idx_inc[array_pkg::MOD_ADDR_W-1:0];
    end else if (restart) begin
      mod_idx <= '0;
    end
  end

  a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
    array_pkg::MOD_CYCLE_W'(mod_idx) < mod_cycle)
    else $error("mod index %0d past cycle length %0d", mod_idx, mod_cycle);

endmodule

// File: design/pwm.sv
`timescale 1ns/1ps
module pwm (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire  [array_pkg::TIME_W-1:0]          time_cnt,
  input  wire                                   update,
  input  wire  [array_pkg::SAMPLE_W-1:0]        intensity,
  input  wire  [array_pkg::SAMPLE_W-1:0]        phase,
  input  wire  [array_pkg::ELEM_W-1:0]          elem_idx,
  input  wire                                   din_valid,
  input  wire  [array_pkg::SAMPLE_W-1:0]        mod_value,
  output logic [array_pkg::NUM_TRANS-1:0]       pwm_out
);

  logic [2*array_pkg::SAMPLE_W-1:0] product;
  logic [array_pkg::SAMPLE_W-1:0]   shadow_width [array_pkg::NUM_TRANS];
  logic [array_pkg::SAMPLE_W-1:0]   shadow_phase [array_pkg::NUM_TRANS];
  logic [array_pkg::SAMPLE_W-1:0]   active_width [array_pkg::NUM_TRANS];
  logic [array_pkg::SAMPLE_W-1:0]   active_phase [array_pkg::NUM_TRANS];

  assign product = intensity * mod_value;  // width is the upper byte

  // ~~~~~~~~~~~~~~~~~~~~
  // shadow and active
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < array_pkg::NUM_TRANS; i++) begin
        shadow_width[i] <= '0;
        shadow_phase[i] <= '0;
      end
    end else if (din_valid) begin
      shadow_width[elem_idx] <= product[2*array_pkg::SAMPLE_W-1:array_pkg::SAMPLE_W];
      shadow_phase[elem_idx] <= phase;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < array_pkg::NUM_TRANS; i++) begin
        active_width[i] <= '0;
        active_phase[i] <= '0;
      end
    end else if (update) begin
      active_width <= shadow_width;  // new frame from time_cnt 0
      active_phase <= shadow_phase;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // output compare
  // ~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < array_pkg::NUM_TRANS; i++) begin : g_out
    logic [array_pkg::TIME_W-1:0] rel_time;

    assign rel_time   = time_cnt - active_phase[i];  // wraps mod 256
    assign pwm_out[i] = rel_time < active_width[i];
  end

  // stm stream must finish well inside one carrier period
  a_no_swap_mid_stream: assert property (@(posedge clk) disable iff (!rst_n)
    !(din_valid && update))
    else $error("frame stream overlaps the update strobe");

endmodule

// File: design/main.sv
`timescale 1ns/1ps
module main (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   wr_en,
  input  array_pkg::wr_target_t                 wr_sel,
  input  wire  [array_pkg::STM_ADDR_W-1:0]      wr_addr,
  input  wire  [array_pkg::DATA_W-1:0]          wr_data,
  output logic [array_pkg::NUM_TRANS-1:0]       pwm_out
);

  logic                               stm_wr;
  logic                               mod_wr;
  logic [array_pkg::STM_ADDR_W-1:0]   tbl_addr;
  logic [array_pkg::DATA_W-1:0]       tbl_data;
  logic [array_pkg::STM_CYCLE_W-1:0]  stm_cycle;
  logic [array_pkg::MOD_CYCLE_W-1:0]  mod_cycle;
  logic                               enable;
  logic                               restart;

  logic [array_pkg::TIME_W-1:0]       time_cnt;
  logic                               update;

  logic [array_pkg::SAMPLE_W-1:0]     intensity;
  logic [array_pkg::SAMPLE_W-1:0]     phase;
  logic [array_pkg::ELEM_W-1:0]       elem_idx;
  logic                               dout_valid;
  logic [array_pkg::SAMPLE_W-1:0]     mod_value;

  controller controller (
    .clk(clk),
    .rst_n(rst_n),
    .wr_en(wr_en),
    .wr_sel(wr_sel),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .stm_wr(stm_wr),
    .mod_wr(mod_wr),
    .tbl_addr(tbl_addr),
    .tbl_data(tbl_data),
    .stm_cycle(stm_cycle),
    .mod_cycle(mod_cycle),
    .enable(enable),
    .restart(restart)
  );

  time_cnt_generator time_cnt_generator (
    .clk(clk),
    .rst_n(rst_n),
    .time_cnt(time_cnt),
    .update(update)
  );

  // stm and modulation run side by side off the same update
  stm stm (
    .clk(clk),
    .rst_n(rst_n),
    .update(update),
    .enable(enable),
    .restart(restart),
    .stm_cycle(stm_cycle),
    .stm_wr(stm_wr),
    .tbl_addr(tbl_addr),
    .tbl_data(tbl_data),
    .intensity(intensity),
    .phase(phase),
    .elem_idx(elem_idx),
    .dout_valid(dout_valid)
  );

  modulation modulation (
    .clk(clk),
    .rst_n(rst_n),
    .update(update),
    .enable(enable),
    .restart(restart),
    .mod_cycle(mod_cycle),
    .mod_wr(mod_wr),
    .tbl_addr(tbl_addr),
    .tbl_data(tbl_data),
    .mod_value(mod_value)
  );

  pwm pwm (
    .clk(clk),
    .rst_n(rst_n),
    .time_cnt(time_cnt),
    .update(update),
    .intensity(intensity),
    .phase(phase),
    .elem_idx(elem_idx),
    .din_valid(dout_valid),
    .mod_value(mod_value),
    .pwm_out(pwm_out)
  );

endmodule

// File: dv/tb_main.sv
`timescale 1ns/1ps
module tb_main;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  wr_en;
  array_pkg::wr_target_t                 wr_sel;
  logic [array_pkg::STM_ADDR_W-1:0]      wr_addr;
  logic [array_pkg::DATA_W-1:0]          wr_data;
  logic [array_pkg::NUM_TRANS-1:0]       pwm_out;

  // reference model state
  logic [array_pkg::DATA_W-1:0]   ref_pattern [array_pkg::NUM_TRANS * array_pkg::STM_FRAMES];
  logic [array_pkg::SAMPLE_W-1:0] ref_mod [array_pkg::MOD_DEPTH];
  logic [array_pkg::SAMPLE_W-1:0] shadow_w [array_pkg::NUM_TRANS];
  logic [array_pkg::SAMPLE_W-1:0] shadow_p [array_pkg::NUM_TRANS];
  logic [array_pkg::SAMPLE_W-1:0] active_w [array_pkg::NUM_TRANS];
  logic [array_pkg::SAMPLE_W-1:0] active_p [array_pkg::NUM_TRANS];
  logic [array_pkg::TIME_W-1:0]   ref_time;
  logic [array_pkg::NUM_TRANS-1:0] exp_out;
  logic                           ref_enable;
  logic                           ever_enabled;
  logic                           shadow_zero;
  logic                           active_zero;
  int unsigned                    ref_stm_cycle;
  int unsigned                    ref_mod_cycle;
  int unsigned                    frame_n;
  int unsigned                    sample_n;
  int unsigned                    update_cnt;
  int unsigned                    cycle_cnt = 0;
  logic [31:0]                    lcg_state;

  main UUT (
    .clk(clk),
    .rst_n(rst_n),
    .wr_en(wr_en),
    .wr_sel(wr_sel),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .pwm_out(pwm_out)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // pulse width is the upper byte of intensity times sample
  function automatic logic [7:0] scaled_width(input logic [7:0] inten, input logic [7:0] sample);
    logic [15:0] prod;
    prod = 16'(inten) * 16'(sample);
    return prod[15:8];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_time      <= '0;
      ref_enable    <= 1'b0;
      ever_enabled  <= 1'b0;
      ref_stm_cycle <= 1;
      ref_mod_cycle <= 1;
      frame_n       <= 0;
      sample_n      <= 0;
      update_cnt    <= 0;
      shadow_zero   <= 1'b0;
      active_zero   <= 1'b0;
      for (int i = 0; i < array_pkg::NUM_TRANS; i++) begin
        shadow_w[i] <= '0;
        shadow_p[i] <= '0;
        active_w[i] <= '0;
        active_p[i] <= '0;
      end
    end else begin
      ref_time <= ref_time + 1'b1;
      if (wr_en && wr_sel == array_pkg::WR_STM) begin
        ref_pattern[wr_addr] <= wr_data;
      end
      if (wr_en && wr_sel == array_pkg::WR_MOD) begin
        ref_mod[wr_addr[array_pkg::MOD_ADDR_W-1:0]] <= wr_data[7:0];
      end
      if (wr_en && wr_sel == array_pkg::WR_CFG) begin
        if (wr_addr[1:0] == array_pkg::CFG_STM_CYCLE) ref_stm_cycle <= 32'(wr_data[2:0]);
        if (wr_addr[1:0] == array_pkg::CFG_MOD_CYCLE) ref_mod_cycle <= 32'(wr_data[4:0]);
        if (wr_addr[1:0] == array_pkg::CFG_ENABLE) begin
          ref_enable   <= wr_data[0];
          ever_enabled <= ever_enabled | wr_data[0];
          if (wr_data[0] && !ref_enable) begin  // restart
            frame_n  <= 0;
            sample_n <= 0;
          end
        end
      end
      if (ref_time == '1) begin  // update, every period
        update_cnt  <= update_cnt + 1;
        active_zero <= shadow_zero;
        for (int i = 0; i < array_pkg::NUM_TRANS; i++) begin
          active_w[i] <= shadow_w[i];
          active_p[i] <= shadow_p[i];
        end
        if (ref_enable) begin
          shadow_zero <= (ref_mod[sample_n] == 8'd0);
          for (int i = 0; i < array_pkg::NUM_TRANS; i++) begin
            shadow_w[i] <= scaled_width(ref_pattern[frame_n * array_pkg::NUM_TRANS + i][15:8],
                                        ref_mod[sample_n]);
            shadow_p[i] <= ref_pattern[frame_n * array_pkg::NUM_TRANS + i][7:0];
          end
          frame_n  <= (frame_n + 1) % ref_stm_cycle;
          sample_n <= (sample_n + 1) % ref_mod_cycle;
        end
      end
    end
  end

  always_comb begin
    logic [7:0] rel;
    for (int i = 0; i < array_pkg::NUM_TRANS; i++) begin
      rel = ref_time - active_p[i];  // mod 256
      exp_out[i] = rel < active_w[i];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < array_pkg::NUM_TRANS; i++) begin : g_bit_chk
    a_pwm_bit: assert property (@(posedge clk) disable iff (!rst_n) pwm_out[i] == exp_out[i])
      else abort_run($sformatf("FAIL %0t pwm_out[%0d] dut=%b exp=%b", $time, i,
                               $sampled(pwm_out[i]), $sampled(exp_out[i])));
  end

  a_low_before_enable: assert property (@(posedge clk) disable iff (!rst_n)
    !ever_enabled |-> pwm_out == '0)
    else abort_run($sformatf("FAIL %0t pwm_out dut=%h exp=00", $time, $sampled(pwm_out)));

  a_zero_sample_low: assert property (@(posedge clk) disable iff (!rst_n)
    active_zero |-> pwm_out == '0)
    else abort_run($sformatf("FAIL %0t pwm_out dut=%h exp=00", $time, $sampled(pwm_out)));

  // about 30 carrier periods of tests
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == 10_000) begin
      abort_run("timeout: the test sequence did not finish within 10000 cycles");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~
  // writes land clear of the stream read window and the update edge
  task automatic host_write(input array_pkg::wr_target_t sel,
                            input logic [array_pkg::STM_ADDR_W-1:0] addr,
                            input logic [array_pkg::DATA_W-1:0] data);
    while (ref_time < 8'd16 || ref_time > 8'd240) begin
      @(posedge clk);
      #1;
    end
    wr_en   = 1'b1;
    wr_sel  = sel;
    wr_addr = addr;
    wr_data = data;
    @(posedge clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic write_cfg(input array_pkg::cfg_addr_t addr, input int value);
    host_write(array_pkg::WR_CFG, 5'(addr), 16'(value));
  endtask

  task automatic wait_updates(input int unsigned n);
    int unsigned target;
    target = update_cnt + n;
    while (update_cnt < target) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    wr_en     = 1'b0;
    wr_sel    = array_pkg::WR_STM;
    wr_addr   = '0;
    wr_data   = '0;
    lcg_state = 32'h7bfe_b4da;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    // full table, element 0 of frame 0 wraps past 255
    for (int a = 0; a < array_pkg::NUM_TRANS * array_pkg::STM_FRAMES; a++) begin
      lcg_state = lcg_next(lcg_state);
      host_write(array_pkg::WR_STM, 5'(a), (a == 0) ? 16'hfff0 : lcg_state[31:16]);
    end
    host_write(array_pkg::WR_MOD, 5'd0, 16'h00ff);
    wait_updates(2);  // not enabled yet

    write_cfg(array_pkg::CFG_STM_CYCLE, 4);
    write_cfg(array_pkg::CFG_ENABLE, 1);
    wait_updates(6);

    write_cfg(array_pkg::CFG_STM_CYCLE, 3);  // frame index is 2 here
    wait_updates(4);

    host_write(array_pkg::WR_MOD, 5'd1, 16'h0080);
    host_write(array_pkg::WR_MOD, 5'd2, 16'h0000);
    host_write(array_pkg::WR_MOD, 5'd3, 16'h0040);
    host_write(array_pkg::WR_MOD, 5'd4, 16'h00c8);
    write_cfg(array_pkg::CFG_MOD_CYCLE, 5);
    wait_updates(7);

    write_cfg(array_pkg::CFG_ENABLE, 0);  // last frame repeats
    wait_updates(3);
    write_cfg(array_pkg::CFG_ENABLE, 1);
    wait_updates(3);

    // rewrite frames 0 and 1 while running
    for (int a = 0; a < 2 * array_pkg::NUM_TRANS; a++) begin
      lcg_state = lcg_next(lcg_state);
      host_write(array_pkg::WR_STM, 5'(a), lcg_state[31:16]);
    end
    host_write(array_pkg::WR_MOD, 5'd3, 16'h0020);
    wait_updates(4);

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: project.f
design/array_pkg.sv
design/controller.sv
design/time_cnt_generator.sv
design/stm.sv
design/modulation.sv
design/pwm.sv
design/main.sv
dv/tb_main.sv

// File: Makefile
# Verilator build and run for the transducer array testbench

SIM := obj_dir/Vtb_main

.PHONY: all run clean

all: run

# rebuilt only when the file list or one of its sources changes
$(SIM): project.f $(shell cat project.f)
	verilator --binary --assert -Wno-fatal --top-module tb_main -f project.f

# the run passes only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
